/* conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

////////////////////////////////////////
// Image geometry
////////////////////////////////////////

// Pixels per word, lane 0 in the low bits
`define WORD_PIX 8

// Words per image row
`define ROW_WORDS 4

// Unsigned pixel width
`define PIX_W 8

////////////////////////////////////////
// Arithmetic
////////////////////////////////////////

// Signed kernel coefficient width
`define COEF_W 8

// Arithmetic right shift before the clamp
`define OUT_SHIFT 4

`endif

/* conv_pkg.sv */
`include "conv_cfg.svh"

package conv_pkg;

    // One unsigned pixel
    typedef logic [`PIX_W-1:0] pixel_t;

    // One bus word of pixels, lane 0 in bits [PIX_W-1:0]
    typedef logic [`WORD_PIX*`PIX_W-1:0] word_t;

    // Line buffer word address
    typedef logic [15:0] buf_adr_t;

    // Buffer selector, 1 to 3 name a buffer and 0 selects none
    typedef logic [1:0] buf_idx_t;

    // One signed kernel coefficient
    typedef logic signed [`COEF_W-1:0] coef_t;

    // Nine coefficients, top-left in the low bits, row-major
    typedef logic [9*`COEF_W-1:0] kernel_t;

    // Left, centre, right pixel from low to high bits
    typedef logic [3*`PIX_W-1:0] tap3_t;

    // Signed sum of one 3x3 window
    typedef logic signed [19:0] acc_t;

    typedef enum logic {
        IDLE,
        SWEEP
    } seq_state_t;

endpackage

/* line_buffer.sv */
`include "conv_cfg.svh"

module line_buffer (
    input  logic               clk,
    input  logic               wr_en,
    input  conv_pkg::buf_adr_t wr_adr,
    input  conv_pkg::word_t    wr_data,
    input  conv_pkg::buf_adr_t rd_adr,
    output conv_pkg::word_t    rd_data
);

    localparam int ADR_W = $clog2(`ROW_WORDS);

    // One image row
    conv_pkg::word_t mem [`ROW_WORDS];

    // Read-first, a write to the read address returns the old word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_adr[ADR_W-1:0]] <= wr_data;
        end
        rd_data <= mem[rd_adr[ADR_W-1:0]];
    end

endmodule

/* row_sequencer.sv */
`include "conv_cfg.svh"

module row_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_sof,
    output logic               wr_en1,
    output logic               wr_en2,
    output logic               wr_en3,
    output conv_pkg::buf_adr_t wr_adr,
    output conv_pkg::buf_adr_t row1_buf_adr,
    output conv_pkg::buf_adr_t row2_buf_adr,
    output conv_pkg::buf_adr_t row3_buf_adr,
    output conv_pkg::buf_idx_t row1_buf_idx,
    output conv_pkg::buf_idx_t row2_buf_idx,
    output conv_pkg::buf_idx_t row3_buf_idx,
    output logic               sweep_valid,
    output logic               sweep_last
);

    conv_pkg::seq_state_t state;
    conv_pkg::buf_adr_t   word_cnt;
    conv_pkg::buf_adr_t   sweep_adr;
    conv_pkg::buf_idx_t   wr_buf;
    conv_pkg::buf_idx_t   cur_buf;
    logic [1:0]           rows_seen;
    logic [1:0]           cur_rows;
    logic                 row_end;

    function automatic conv_pkg::buf_idx_t next_buf(input conv_pkg::buf_idx_t b);
        return (b == 2'd3) ? 2'd1 : b + 2'd1;
    endfunction

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    // in_sof restarts word, buffer and row count in the same cycle
    assign wr_adr   = in_sof ? '0 : word_cnt;
    assign cur_buf  = in_sof ? 2'd1 : wr_buf;
    assign cur_rows = in_sof ? 2'd0 : rows_seen;
    assign row_end  = in_valid && (wr_adr == `ROW_WORDS - 1);

    assign wr_en1 = in_valid && (cur_buf == 2'd1);
    assign wr_en2 = in_valid && (cur_buf == 2'd2);
    assign wr_en3 = in_valid && (cur_buf == 2'd3);

    // Completed rows, saturating at two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt  <= '0;
            wr_buf    <= 2'd1;
            rows_seen <= '0;
        end else if (in_valid) begin
            if (row_end) begin
                word_cnt  <= '0;
                wr_buf    <= next_buf(cur_buf);
                rows_seen <= (cur_rows == 2'd2) ? cur_rows : cur_rows + 2'd1;
            end else begin
                word_cnt  <= wr_adr + 1'b1;
                wr_buf    <= cur_buf;
                rows_seen <= cur_rows;
            end
        end
    end

    ////////////////////////////////////////
    // Read sweep
    ////////////////////////////////////////

    // One address for all three rows
    assign row1_buf_adr = sweep_adr;
    assign row2_buf_adr = sweep_adr;
    assign row3_buf_adr = sweep_adr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= conv_pkg::IDLE;
            sweep_adr    <= '0;
            row1_buf_idx <= '0;
            row2_buf_idx <= '0;
            row3_buf_idx <= '0;
            sweep_valid  <= 1'b0;
            sweep_last   <= 1'b0;
        end else begin
            // Flags follow the address by the RAM latency
            sweep_valid <= (state == conv_pkg::SWEEP);
            sweep_last  <= (state == conv_pkg::SWEEP) && (sweep_adr == `ROW_WORDS - 1);
            if (row_end && (cur_rows == 2'd2)) begin
                // Oldest row sits in the buffer written next
                state        <= conv_pkg::SWEEP;
                sweep_adr    <= '0;
                row1_buf_idx <= next_buf(cur_buf);
                row2_buf_idx <= next_buf(next_buf(cur_buf));
                row3_buf_idx <= cur_buf;
            end else if (state == conv_pkg::SWEEP) begin
                if (sweep_adr == `ROW_WORDS - 1) begin
                    state        <= conv_pkg::IDLE;
                    sweep_adr    <= '0;
                    row1_buf_idx <= '0;
                    row2_buf_idx <= '0;
                    row3_buf_idx <= '0;
                end else begin
                    sweep_adr <= sweep_adr + 1'b1;
                end
            end
        end
    end

endmodule

/* conv_bram_handler.sv */
module conv_bram_handler (
    input  logic               clk,
    input  logic               rst_n,
    input  conv_pkg::buf_adr_t row1_buf_adr,
    input  conv_pkg::buf_idx_t row1_buf_idx,
    input  conv_pkg::buf_adr_t row2_buf_adr,
    input  conv_pkg::buf_idx_t row2_buf_idx,
    input  conv_pkg::buf_adr_t row3_buf_adr,
    input  conv_pkg::buf_idx_t row3_buf_idx,
    input  conv_pkg::word_t    buf1_pixels,
    input  conv_pkg::word_t    buf2_pixels,
    input  conv_pkg::word_t    buf3_pixels,
    output conv_pkg::buf_adr_t buf1_adr,
    output conv_pkg::buf_adr_t buf2_adr,
    output conv_pkg::buf_adr_t buf3_adr,
    output conv_pkg::word_t    row1_pixels,
    output conv_pkg::word_t    row2_pixels,
    output conv_pkg::word_t    row3_pixels
);

    // Indices as seen by the RAM data, one cycle late
    conv_pkg::buf_idx_t row1_idx_q;
    conv_pkg::buf_idx_t row2_idx_q;
    conv_pkg::buf_idx_t row3_idx_q;

    // Address crossbar, row 1 has priority
    assign buf1_adr = (row1_buf_idx == 2'd1) ? row1_buf_adr :
                      (row2_buf_idx == 2'd1) ? row2_buf_adr :
                      (row3_buf_idx == 2'd1) ? row3_buf_adr : '0;
    assign buf2_adr = (row1_buf_idx == 2'd2) ? row1_buf_adr :
                      (row2_buf_idx == 2'd2) ? row2_buf_adr :
                      (row3_buf_idx == 2'd2) ? row3_buf_adr : '0;
    assign buf3_adr = (row1_buf_idx == 2'd3) ? row1_buf_adr :
                      (row2_buf_idx == 2'd3) ? row2_buf_adr :
                      (row3_buf_idx == 2'd3) ? row3_buf_adr : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row1_idx_q <= '0;
            row2_idx_q <= '0;
            row3_idx_q <= '0;
        end else begin
            row1_idx_q <= row1_buf_idx;
            row2_idx_q <= row2_buf_idx;
            row3_idx_q <= row3_buf_idx;
        end
    end

    // Data crossbar
    assign row1_pixels = (row1_idx_q == 2'd1) ? buf1_pixels :
                         (row1_idx_q == 2'd2) ? buf2_pixels :
                         (row1_idx_q == 2'd3) ? buf3_pixels : '0;
    assign row2_pixels = (row2_idx_q == 2'd1) ? buf1_pixels :
                         (row2_idx_q == 2'd2) ? buf2_pixels :
                         (row2_idx_q == 2'd3) ? buf3_pixels : '0;
    assign row3_pixels = (row3_idx_q == 2'd1) ? buf1_pixels :
                         (row3_idx_q == 2'd2) ? buf2_pixels :
                         (row3_idx_q == 2'd3) ? buf3_pixels : '0;

endmodule

/* window_former.sv */
`include "conv_cfg.svh"

module window_former (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            row_valid,
    input  logic            row_last,
    input  conv_pkg::word_t row1_pixels,
    input  conv_pkg::word_t row2_pixels,
    input  conv_pkg::word_t row3_pixels,
    output logic            win_valid,
    output conv_pkg::tap3_t win_top [`WORD_PIX],
    output conv_pkg::tap3_t win_mid [`WORD_PIX],
    output conv_pkg::tap3_t win_bot [`WORD_PIX]
);

    localparam int EXT_W = (`WORD_PIX + 2) * `PIX_W;

    conv_pkg::word_t  in_w   [3];
    conv_pkg::word_t  prev_w [3];
    conv_pkg::word_t  cur_w  [3];
    conv_pkg::pixel_t left_pix  [3];
    conv_pkg::pixel_t right_pix [3];
    logic [EXT_W-1:0] ext    [3];
    logic             have_cur;
    logic             flush;
    logic             emit;

    assign in_w[0] = row1_pixels;
    assign in_w[1] = row2_pixels;
    assign in_w[2] = row3_pixels;

    // Window for cur_w once its right neighbour is known
    assign emit = flush || (row_valid && have_cur);

    // Current word widened by one pixel on each side
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            left_pix[r]  = prev_w[r][`WORD_PIX*`PIX_W-1 -: `PIX_W];
            right_pix[r] = flush ? '0 : in_w[r][`PIX_W-1:0];
            ext[r]       = {right_pix[r], cur_w[r], left_pix[r]};
        end
    end

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_cur  <= 1'b0;
            flush     <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= emit;
            if (row_valid) begin
                // Next row may begin in the flush cycle
                have_cur <= 1'b1;
                flush    <= row_last;
            end else if (flush) begin
                // Right edge done and row closed
                flush    <= 1'b0;
                have_cur <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Word history and windows
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (row_valid) begin
            for (int r = 0; r < 3; r++) begin
                // Zero left neighbour for the first word
                prev_w[r] <= (have_cur && !flush) ? cur_w[r] : '0;
                cur_w[r]  <= in_w[r];
            end
        end
        if (emit) begin
            for (int i = 0; i < `WORD_PIX; i++) begin
                win_top[i] <= ext[0][i*`PIX_W +: 3*`PIX_W];
                win_mid[i] <= ext[1][i*`PIX_W +: 3*`PIX_W];
                win_bot[i] <= ext[2][i*`PIX_W +: 3*`PIX_W];
            end
        end
    end

endmodule

/* conv_lane.sv */
`include "conv_cfg.svh"

module conv_lane (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              win_valid,
    input  conv_pkg::tap3_t   win_top,
    input  conv_pkg::tap3_t   win_mid,
    input  conv_pkg::tap3_t   win_bot,
    input  conv_pkg::kernel_t kernel,
    output logic              lane_valid,
    output conv_pkg::acc_t    lane_sum
);

    conv_pkg::tap3_t              rows [3];
    logic signed [`PIX_W+`COEF_W:0] prod [9];
    logic                         prod_valid;
    conv_pkg::acc_t               sum;

    assign rows[0] = win_top;
    assign rows[1] = win_mid;
    assign rows[2] = win_bot;

    // Stage one, nine signed products
    always_ff @(posedge clk) begin
        conv_pkg::pixel_t pix;
        conv_pkg::coef_t  coef;
        if (win_valid) begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    pix  = rows[r][c*`PIX_W +: `PIX_W];
                    coef = kernel[(r*3+c)*`COEF_W +: `COEF_W];
                    prod[r*3+c] <= $signed({1'b0, pix}) * coef;
                end
            end
        end
    end

    // Adder tree input
    always_comb begin
        sum = '0;
        for (int k = 0; k < 9; k++) begin
            sum = sum + prod[k];
        end
    end

    // Stage two, registered sum
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            lane_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            lane_valid <= prod_valid;
        end
        if (prod_valid) begin
            lane_sum <= sum;
        end
    end

endmodule

/* output_packer.sv */
`include "conv_cfg.svh"

module output_packer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`WORD_PIX-1:0] lane_valid,
    input  conv_pkg::acc_t       lane_sum [`WORD_PIX],
    output logic                 out_valid,
    output conv_pkg::word_t      out_pixels
);

    conv_pkg::word_t packed_w;

    // Scale, then clamp to the pixel range
    always_comb begin
        conv_pkg::acc_t   scaled;
        conv_pkg::pixel_t pix;
        for (int i = 0; i < `WORD_PIX; i++) begin
            scaled = lane_sum[i] >>> `OUT_SHIFT;
            if (scaled < 0) begin
                pix = '0;
            end else if (scaled > (1 << `PIX_W) - 1) begin
                pix = '1;
            end else begin
                pix = scaled[`PIX_W-1:0];
            end
            packed_w[i*`PIX_W +: `PIX_W] = pix;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= &lane_valid;
        end
        if (&lane_valid) begin
            out_pixels <= packed_w;
        end
    end

endmodule

/* conv_top.sv */
`include "conv_cfg.svh"

module conv_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              in_sof,
    input  conv_pkg::word_t   in_pixels,
    input  conv_pkg::kernel_t kernel,
    output logic              out_valid,
    output conv_pkg::word_t   out_pixels
);

    logic                 wr_en1;
    logic                 wr_en2;
    logic                 wr_en3;
    conv_pkg::buf_adr_t   wr_adr;
    conv_pkg::buf_adr_t   row1_buf_adr;
    conv_pkg::buf_adr_t   row2_buf_adr;
    conv_pkg::buf_adr_t   row3_buf_adr;
    conv_pkg::buf_idx_t   row1_buf_idx;
    conv_pkg::buf_idx_t   row2_buf_idx;
    conv_pkg::buf_idx_t   row3_buf_idx;
    logic                 sweep_valid;
    logic                 sweep_last;
    conv_pkg::buf_adr_t   buf1_adr;
    conv_pkg::buf_adr_t   buf2_adr;
    conv_pkg::buf_adr_t   buf3_adr;
    conv_pkg::word_t      buf1_pixels;
    conv_pkg::word_t      buf2_pixels;
    conv_pkg::word_t      buf3_pixels;
    conv_pkg::word_t      row1_pixels;
    conv_pkg::word_t      row2_pixels;
    conv_pkg::word_t      row3_pixels;
    logic                 win_valid;
    conv_pkg::tap3_t      win_top [`WORD_PIX];
    conv_pkg::tap3_t      win_mid [`WORD_PIX];
    conv_pkg::tap3_t      win_bot [`WORD_PIX];
    logic [`WORD_PIX-1:0] lane_valid;
    conv_pkg::acc_t       lane_sum [`WORD_PIX];

    ////////////////////////////////////////
    // Row storage
    ////////////////////////////////////////

    row_sequencer u_seq (
        .clk, .rst_n, .in_valid, .in_sof,
        .wr_en1, .wr_en2, .wr_en3, .wr_adr,
        .row1_buf_adr, .row2_buf_adr, .row3_buf_adr,
        .row1_buf_idx, .row2_buf_idx, .row3_buf_idx,
        .sweep_valid, .sweep_last
    );

    line_buffer u_buf1 (
        .clk, .wr_en(wr_en1), .wr_adr, .wr_data(in_pixels),
        .rd_adr(buf1_adr), .rd_data(buf1_pixels)
    );

    line_buffer u_buf2 (
        .clk, .wr_en(wr_en2), .wr_adr, .wr_data(in_pixels),
        .rd_adr(buf2_adr), .rd_data(buf2_pixels)
    );

    line_buffer u_buf3 (
        .clk, .wr_en(wr_en3), .wr_adr, .wr_data(in_pixels),
        .rd_adr(buf3_adr), .rd_data(buf3_pixels)
    );

    conv_bram_handler u_handler (
        .clk, .rst_n,
        .row1_buf_adr, .row1_buf_idx, .row2_buf_adr, .row2_buf_idx,
        .row3_buf_adr, .row3_buf_idx,
        .buf1_pixels, .buf2_pixels, .buf3_pixels,
        .buf1_adr, .buf2_adr, .buf3_adr,
        .row1_pixels, .row2_pixels, .row3_pixels
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    window_former u_former (
        .clk, .rst_n,
        .row_valid(sweep_valid), .row_last(sweep_last),
        .row1_pixels, .row2_pixels, .row3_pixels,
        .win_valid, .win_top, .win_mid, .win_bot
    );

    // One lane per pixel of the word
    for (genvar i = 0; i < `WORD_PIX; i++) begin : g_lane
        conv_lane u_lane (
            .clk, .rst_n, .win_valid,
            .win_top(win_top[i]), .win_mid(win_mid[i]), .win_bot(win_bot[i]),
            .kernel, .lane_valid(lane_valid[i]), .lane_sum(lane_sum[i])
        );
    end

    output_packer u_packer (
        .clk, .rst_n, .lane_valid, .lane_sum, .out_valid, .out_pixels
    );

endmodule

/* tb_clock.sv */
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    localparam realtime HALF_PERIOD = 4ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

/* tb_conv.sv */
`include "conv_cfg.svh"

module tb_conv;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_H      = 8;
    localparam int NUM_FRAMES = 11;
    localparam int ROW_PIX    = `ROW_WORDS * `WORD_PIX;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_sof;
    conv_pkg::word_t   in_pixels;
    conv_pkg::kernel_t kernel;
    logic              out_valid;
    conv_pkg::word_t   out_pixels;

    conv_pkg::word_t   frame_rows [MAX_H][`ROW_WORDS];
    conv_pkg::word_t   exp_q [$];
    int                start_q [$];
    int                heights [NUM_FRAMES];
    int unsigned       lcg_state;
    int                cyc = 0;
    int                burst_pos = 0;
    int                exp_start;
    int                errors = 0;
    int                words_seen = 0;
    int                limit_cycles;
    int                tests_run;
    int                test_words_exp;
    int                test_words_base;
    int                test_err_base;
    string             test_name = "reset";

    tb_clock clk_gen (.clk);

    conv_top dut0 (
        .clk, .rst_n, .in_valid, .in_sof, .in_pixels, .kernel,
        .out_valid, .out_pixels
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int unsigned span;
        span = hi - lo + 1;
        return lo + int'(next_rand() % span);
    endfunction

    // Zero outside the row
    function automatic int pixel_at(input int r, input int x);
        conv_pkg::pixel_t p;
        if (x < 0 || x >= ROW_PIX) begin
            return 0;
        end
        p = frame_rows[r][x / `WORD_PIX][(x % `WORD_PIX)*`PIX_W +: `PIX_W];
        return int'(p);
    endfunction

    // Output word w of centre row r
    function automatic conv_pkg::word_t expect_word(input int r, input int w);
        conv_pkg::word_t res;
        conv_pkg::coef_t c;
        int acc;
        int x;
        res = '0;
        for (int i = 0; i < `WORD_PIX; i++) begin
            acc = 0;
            x = w * `WORD_PIX + i;
            for (int dy = 0; dy < 3; dy++) begin
                for (int dx = 0; dx < 3; dx++) begin
                    c = kernel[(dy*3+dx)*`COEF_W +: `COEF_W];
                    acc += int'(c) * pixel_at(r - 1 + dy, x - 1 + dx);
                end
            end
            acc = acc >>> `OUT_SHIFT;
            if (acc < 0) begin
                acc = 0;
            end else if (acc > (1 << `PIX_W) - 1) begin
                acc = (1 << `PIX_W) - 1;
            end
            res[i*`PIX_W +: `PIX_W] = acc[`PIX_W-1:0];
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_word(input string name, input conv_pkg::word_t exp_w,
                              input conv_pkg::word_t act_w);
        if (act_w !== exp_w) begin
            $display("Mismatch %s word: expected %h, actual %h", name, exp_w, act_w);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("Mismatch %s word count: expected %0d, actual %0d", name, exp_n, act_n);
            errors++;
        end
    endtask

    // Output monitor, bursts of ROW_WORDS with a fixed start cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (out_valid === 1'b1) begin
                if (burst_pos == 0) begin
                    if (start_q.size() == 0) begin
                        $display("%s: output burst that no row should cause, cycle %0d",
                                 test_name, cyc);
                        errors++;
                    end else begin
                        exp_start = start_q.pop_front();
                        if (exp_start != cyc) begin
                            $display("%s: burst started at cycle %0d instead of cycle %0d",
                                     test_name, cyc, exp_start);
                            errors++;
                        end
                    end
                end
                if (exp_q.size() == 0) begin
                    $display("%s: output word %h arrived with none expected",
                             test_name, out_pixels);
                    errors++;
                end else begin
                    check_word(test_name, exp_q.pop_front(), out_pixels);
                end
                words_seen++;
                burst_pos = (burst_pos == `ROW_WORDS - 1) ? 0 : burst_pos + 1;
            end else if (burst_pos != 0) begin
                $display("%s: output burst broke off after %0d words", test_name, burst_pos);
                errors++;
                burst_pos = 0;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic random_kernel();
        conv_pkg::coef_t c;
        for (int k = 0; k < 9; k++) begin
            c = conv_pkg::coef_t'(rand_range(-24, 40));
            kernel[k*`COEF_W +: `COEF_W] = c;
        end
    endtask

    task automatic make_frame(input int h);
        conv_pkg::word_t wd;
        for (int r = 0; r < h; r++) begin
            for (int w = 0; w < `ROW_WORDS; w++) begin
                for (int i = 0; i < `WORD_PIX; i++) begin
                    wd[i*`PIX_W +: `PIX_W] = conv_pkg::pixel_t'(next_rand());
                end
                frame_rows[r][w] = wd;
            end
        end
        test_words_exp += (h >= 3) ? (h - 2) * `ROW_WORDS : 0;
    endtask

    // Gap mode 0 and 1 are fixed gaps, 2 draws 0 to 3 idle cycles
    task automatic send_frame(input int h, input int gap_mode);
        int gap;
        for (int r = 0; r < h; r++) begin
            for (int w = 0; w < `ROW_WORDS; w++) begin
                in_valid  = 1'b1;
                in_sof    = (r == 0) && (w == 0);
                in_pixels = frame_rows[r][w];
                if ((w == `ROW_WORDS - 1) && (r >= 2)) begin
                    // Accepted at the next rising edge, first output 6 edges later
                    start_q.push_back(cyc + 7);
                    for (int k = 0; k < `ROW_WORDS; k++) begin
                        exp_q.push_back(expect_word(r - 1, k));
                    end
                end
                @(negedge clk);
                in_valid = 1'b0;
                in_sof   = 1'b0;
                gap = (gap_mode == 2) ? rand_range(0, 3) : gap_mode;
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    // Wait out the pipeline, longer than row end to last output
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (`ROW_WORDS + 8) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        test_words_exp  = 0;
        test_words_base = words_seen;
        test_err_base   = errors;
    endtask

    task automatic end_test();
        drain();
        check_count(test_name, test_words_exp, words_seen - test_words_base);
        tests_run++;
        $display("test %0d %s done: %0d words, %0d errors", tests_run, test_name,
                 words_seen - test_words_base, errors - test_err_base);
    endtask

    task automatic watchdog();
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    endtask

    initial begin
        int total_words;
        lcg_state = 33009;
        tests_run = 0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_sof    = 1'b0;
        in_pixels = '0;
        kernel    = '0;

        // Frame heights of all tests, frame 0 has only two rows
        heights[0] = 2;
        total_words = 2 * `ROW_WORDS;
        for (int f = 1; f < NUM_FRAMES; f++) begin
            heights[f] = rand_range(3, MAX_H);
            total_words += heights[f] * `ROW_WORDS;
        end
        limit_cycles = total_words * 4 + 200;
        fork
            watchdog();
        join_none

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset_idle");
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("reset_idle: out_valid is not low after reset");
            errors++;
        end
        make_frame(heights[0]);
        send_frame(heights[0], 0);
        end_test();

        // Centre tap 16 undoes the shift
        begin_test("identity");
        kernel = '0;
        kernel[4*`COEF_W +: `COEF_W] = 8'sd16;
        make_frame(heights[1]);
        send_frame(heights[1], 1);
        end_test();

        begin_test("random_kernel");
        for (int f = 2; f < 5; f++) begin
            random_kernel();
            make_frame(heights[f]);
            send_frame(heights[f], 1);
            drain();
        end
        end_test();

        // Next frame follows the last word directly
        begin_test("back_to_back");
        random_kernel();
        for (int f = 5; f < 7; f++) begin
            make_frame(heights[f]);
            send_frame(heights[f], 0);
        end
        end_test();

        begin_test("gaps_frames");
        for (int f = 7; f < 9; f++) begin
            random_kernel();
            make_frame(heights[f]);
            send_frame(heights[f], 2);
            drain();
        end
        random_kernel();
        for (int f = 9; f < NUM_FRAMES; f++) begin
            make_frame(heights[f]);
            send_frame(heights[f], 2);
        end
        end_test();

        $display("tests %0d, words checked %0d, errors %0d", tests_run, words_seen, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
conv_pkg.sv
line_buffer.sv
row_sequencer.sv
conv_bram_handler.sv
window_former.sv
conv_lane.sv
output_packer.sv
conv_top.sv
tb_clock.sv
tb_conv.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_conv -o sim_conv
./obj_dir/sim_conv > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
